// ==== verilog.f ====
+incdir+tb
src/regBankPkg.sv
src/pipeCtrlPkg.sv
src/decodeAddrIf.sv
src/pipeAddrIf.sv
src/bankAddrDecode.sv
src/regAddrSelect.sv
src/addrPipeline.sv
src/hazardMatch.sv
src/addressPath.sv
tb/addressPathTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the address path testbench, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module addressPathTb -f verilog.f \
  > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/VaddressPathTb > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1
grep -q "PASS: all tests" sim.log || exit 1
exit 0

// ==== tb/addrModelTasks.svh ====
`ifndef ADDR_MODEL_TASKS_SVH
`define ADDR_MODEL_TASKS_SVH
`default_nettype none

// Stimulus row, stall and flush bits in ctl with stallE on top
typedef struct packed {
  logic [31:0] instr;
  logic        mult;
  logic        aluSrc;
  logic [3:0]  rz;
  logic [1:0]  regSrc;
  logic [7:0]  cpsr;
  logic [5:0]  ctl;
} rowT;

// Shadow Execute, Memory and Writeback state
execAddrT    shExec = '0;
memAddrT     shMem = '0;
wbAddrT      shWb = '0;
logic        shM1 = 1'b0;
logic        shM2 = 1'b0;
int          curRow = 0;
logic [31:0] lfsrState = 32'ha8d3_1e24;

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic nextBit();
  logic fb;
  fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
  lfsrState = {lfsrState[30:0], fb};
  return fb;
endfunction

// One step per bit taken
function automatic logic [31:0] randField(input int width);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < width; i++) v = {v[30:0], nextBit()};
  return v;
endfunction

// ==============================
// Reference banking map
// ==============================
function automatic regOneHotT bankSel(input regNumT r, input logic ub, input logic [4:0] m);
  int idx;
  idx = int'(r);
  // fiq owns R8 to R14
  if (!ub && m == 5'b10001 && r >= 4'd8 && r <= 4'd14) begin
    idx = 16 + int'(r) - 8;
  end else if (!ub && (r == 4'd13 || r == 4'd14)) begin
    case (m)
      5'b10010: idx = 23 + int'(r) - 13;
      5'b10011: idx = 25 + int'(r) - 13;
      5'b10111: idx = 27 + int'(r) - 13;
      5'b11011: idx = 29 + int'(r) - 13;
      default:  idx = int'(r);
    endcase
  end
  return 32'h1 << idx;
endfunction

// Decode-stage selects expected for one row
function automatic execAddrT decodeModel(input rowT r);
  regNumT   n1;
  regNumT   n2;
  regNumT   nw;
  execAddrT e;
  n1 = r.mult ? r.instr[3:0] : (r.regSrc[0] ? 4'hf : r.instr[19:16]);
  // Rs of a register-shifted operand
  if (r.rz[2] && r.rz[3] && !r.mult) n1 = r.instr[11:8];
  n2 = r.mult ? r.instr[11:8] : (r.regSrc[1] ? r.instr[15:12] : r.instr[3:0]);
  nw = r.mult ? r.instr[19:16] : r.instr[15:12];
  e.ra1    = bankSel(n1, r.rz[0], r.cpsr[4:0]);
  e.ra2    = bankSel(n2, r.rz[1], r.cpsr[4:0]);
  e.wa3    = bankSel(nw, r.rz[2], r.cpsr[4:0]);
  e.op2Reg = !r.mult && !r.regSrc[1] && !r.aluSrc;
  return e;
endfunction

// Shadow stages at one rising edge, oldest first
task automatic advanceModel(input logic [5:0] ctl, input execAddrT d,
                            input logic de1, input logic de2);
  if (ctl[0]) shWb = '0;
  else if (!ctl[1]) shWb.wa3 = shMem.wa3;
  if (ctl[2]) begin
    shMem = '0;
    shM1  = 1'b0;
    shM2  = 1'b0;
  end else if (!ctl[3]) begin
    shMem.wa3 = shExec.wa3;
    shM1      = de1;
    shM2      = de2;
  end
  if (ctl[4]) shExec = '0;
  else if (!ctl[5]) shExec = d;
endtask

task automatic checkOneHot(input string name, input regOneHotT actual,
                           input regOneHotT expected);
  if (actual !== expected) begin
    $display("[FAIL] %s row %0d: got %h expected %h", name, curRow, actual, expected);
    stopRun();
  end
endtask

task automatic checkFlag(input string name, input logic actual, input logic expected);
  if (actual !== expected) begin
    $display("[FAIL] %s row %0d: got %h expected %h", name, curRow, actual, expected);
    stopRun();
  end
endtask

`default_nettype wire
`endif

// ==== tb/addressPathTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module addressPathTb
  import regBankPkg::*, pipeCtrlPkg::*;
();

  localparam int maxCycles     = 2000;
  localparam int randRows      = 150;

  // Control bits of a row
  localparam logic [5:0] ctlNone   = 6'b000000;
  localparam logic [5:0] ctlStallE = 6'b100000;
  localparam logic [5:0] ctlFlushE = 6'b010000;
  localparam logic [5:0] ctlStallM = 6'b001000;
  localparam logic [5:0] ctlFlushM = 6'b000100;
  localparam logic [5:0] ctlStallW = 6'b000010;
  localparam logic [5:0] ctlFlushW = 6'b000001;

  // Seven listed modes and two that are not
  localparam logic [4:0] modeList [0:8] = '{
    5'b10000, 5'b10001, 5'b10010, 5'b10011, 5'b10111,
    5'b11011, 5'b11111, 5'b10110, 5'b00101
  };

  logic        clk;
  logic        rstN;
  logic [31:0] instrD;
  logic        multSelectD;
  logic        aluSrcD;
  logic [3:0]  regFileRzD;
  logic [1:0]  regSrcD;
  logic [7:0]  cpsr8W;
  logic        stallE;
  logic        flushE;
  logic        stallM;
  logic        flushM;
  logic        stallW;
  logic        flushW;
  regOneHotT   ra1D;
  regOneHotT   ra2D;
  regOneHotT   wa3W;
  logic        match1DE;
  logic        match2DE;
  logic        match1EM;
  logic        match2EM;
  logic        match1EW;
  logic        match2EW;

  task automatic stopRun();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  `include "addrModelTasks.svh"

  rowT rows[$];

  addressPath u_dut (
    .clk(clk), .rstN(rstN), .instrD(instrD), .multSelectD(multSelectD),
    .aluSrcD(aluSrcD), .regFileRzD(regFileRzD), .regSrcD(regSrcD), .cpsr8W(cpsr8W),
    .stallE(stallE), .flushE(flushE), .stallM(stallM), .flushM(flushM),
    .stallW(stallW), .flushW(flushW), .ra1D(ra1D), .ra2D(ra2D), .wa3W(wa3W),
    .match1DE(match1DE), .match2DE(match2DE), .match1EM(match1EM),
    .match2EM(match2EM), .match1EW(match1EW), .match2EW(match2EW)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Watchdog
  initial begin
    for (int c = 0; c < maxCycles; c++) @(posedge clk);
    $display("Simulation ran past %0d cycles without finishing", maxCycles);
    stopRun();
  end

  task automatic addRow(input logic [31:0] instr, input logic mult, input logic aluSrc,
                        input logic [3:0] rz, input logic [1:0] regSrc,
                        input logic [4:0] mode, input logic [5:0] ctl);
    rowT r;
    r.instr  = instr;
    r.mult   = mult;
    r.aluSrc = aluSrc;
    r.rz     = rz;
    r.regSrc = regSrc;
    r.cpsr   = {3'b000, mode};
    r.ctl    = ctl;
    rows.push_back(r);
  endtask

  // ==============================
  // Stimulus table
  // ==============================
  task automatic buildTable();
    // Rn sweep on read 1 in every mode
    for (int m = 0; m < 9; m++) begin
      for (int n = 0; n < 16; n++) begin
        addRow({12'h000, 4'(n), 16'h0000}, 1'b0, 1'b0, 4'h0, 2'b00, modeList[4'(m)], ctlNone);
      end
    end
    // User bank forced on one port at a time
    addRow(32'h000d_e00d, 1'b0, 1'b0, 4'b0001, 2'b00, modeFiq, ctlNone);
    addRow(32'h000d_e00d, 1'b0, 1'b0, 4'b0010, 2'b00, modeFiq, ctlNone);
    addRow(32'h000d_e00d, 1'b0, 1'b0, 4'b0100, 2'b00, modeFiq, ctlNone);
    // Rs from 11:8
    addRow(32'h0001_2a03, 1'b0, 1'b0, 4'b1100, 2'b00, modeIrq, ctlNone);
    // Multiply, then PC read, then store data on read 2
    addRow(32'h0007_0905, 1'b1, 1'b0, 4'h0, 2'b00, modeSvc, ctlNone);
    addRow(32'h0004_5006, 1'b0, 1'b0, 4'h0, 2'b01, modeUser, ctlNone);
    addRow(32'h0004_5006, 1'b0, 1'b0, 4'h0, 2'b10, modeUser, ctlNone);
    // R3 written, read next, then read with an immediate
    addRow(32'h0001_3002, 1'b0, 1'b0, 4'h0, 2'b00, modeUser, ctlNone);
    addRow(32'h0003_3003, 1'b0, 1'b0, 4'h0, 2'b00, modeUser, ctlNone);
    addRow(32'h0003_6003, 1'b0, 1'b1, 4'h0, 2'b00, modeUser, ctlNone);
    addRow(32'h0004_7003, 1'b0, 1'b0, 4'h0, 2'b00, modeUser, ctlNone);
    // Writeback hold then a flush per stage
    addRow(32'h0001_8002, 1'b0, 1'b0, 4'h0, 2'b00, modeUser, ctlNone);
    addRow(32'h0001_9002, 1'b0, 1'b0, 4'h0, 2'b00, modeUser, ctlStallW);
    addRow(32'h0001_a002, 1'b0, 1'b0, 4'h0, 2'b00, modeUser, ctlStallW);
    addRow(32'h0001_b002, 1'b0, 1'b0, 4'h0, 2'b00, modeUser, ctlNone);
    addRow(32'h0001_c002, 1'b0, 1'b0, 4'h0, 2'b00, modeUser, ctlFlushW);
    addRow(32'h000c_d00c, 1'b0, 1'b0, 4'h0, 2'b00, modeUser, ctlFlushM);
    addRow(32'h000d_e00d, 1'b0, 1'b0, 4'h0, 2'b00, modeAbort, ctlStallE | ctlStallM);
    addRow(32'h000e_200e, 1'b0, 1'b0, 4'h0, 2'b00, modeUndef, ctlFlushE);
    for (int k = 0; k < 3; k++) begin
      addRow(32'h0002_1002, 1'b0, 1'b0, 4'h0, 2'b00, modeUser, ctlNone);
    end
    // Random rows, stall and flush bits set about one time in eight
    for (int k = 0; k < randRows; k++) begin
      addRow(randField(32), 1'(randField(1)), 1'(randField(1)), 4'(randField(4)),
             2'(randField(2)), modeList[4'(randField(3))],
             6'(randField(6) & randField(6) & randField(6)));
    end
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    rowT      r;
    execAddrT d;
    execAddrT prevDec;
    logic     de1;
    logic     de2;
    logic     prevDe1;
    logic     prevDe2;
    logic [5:0] prevCtl;
    rstN        = 1'b0;
    instrD      = '0;
    multSelectD = 1'b0;
    aluSrcD     = 1'b0;
    regFileRzD  = '0;
    regSrcD     = '0;
    cpsr8W      = '0;
    stallE      = 1'b0;
    flushE      = 1'b0;
    stallM      = 1'b0;
    flushM      = 1'b0;
    stallW      = 1'b0;
    flushW      = 1'b0;
    buildTable();
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    // Reset must leave Writeback and registered flags clear
    @(negedge clk);
    checkOneHot("wa3W", wa3W, '0);
    checkFlag("match1EM", match1EM, 1'b0);
    checkFlag("match2EM", match2EM, 1'b0);
    // All-zero inputs are sampled at the first edge after reset
    prevCtl = ctlNone;
    prevDec = decodeModel('0);
    prevDe1 = 1'b0;
    prevDe2 = 1'b0;
    foreach (rows[i]) begin
      r      = rows[i];
      curRow = i;
      @(posedge clk);
      instrD      <= r.instr;
      multSelectD <= r.mult;
      aluSrcD     <= r.aluSrc;
      regFileRzD  <= r.rz;
      regSrcD     <= r.regSrc;
      cpsr8W      <= r.cpsr;
      {stallE, flushE, stallM, flushM, stallW, flushW} <= r.ctl;
      advanceModel(prevCtl, prevDec, prevDe1, prevDe2);
      @(negedge clk);
      d   = decodeModel(r);
      de1 = (|shExec.wa3) && d.ra1 == shExec.wa3;
      de2 = (|shExec.wa3) && d.op2Reg && d.ra2 == shExec.wa3;
      checkOneHot("ra1D", ra1D, d.ra1);
      checkOneHot("ra2D", ra2D, d.ra2);
      checkOneHot("wa3W", wa3W, shWb.wa3);
      checkFlag("match1DE", match1DE, de1);
      checkFlag("match2DE", match2DE, de2);
      checkFlag("match1EM", match1EM, shM1);
      checkFlag("match2EM", match2EM, shM2);
      checkFlag("match1EW", match1EW, (|shWb.wa3) && shExec.ra1 == shWb.wa3);
      checkFlag("match2EW", match2EW,
                (|shWb.wa3) && shExec.op2Reg && shExec.ra2 == shWb.wa3);
      prevCtl = r.ctl;
      prevDec = d;
      prevDe1 = de1;
      prevDe2 = de2;
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/addressPath.sv ====
`timescale 1ns/1ps
`default_nettype none

module addressPath
  import regBankPkg::*;
(
  input  logic        clk,
  input  logic        rstN,
  // Decode inputs
  input  logic [31:0] instrD,
  input  logic        multSelectD,
  input  logic        aluSrcD,
  input  logic [3:0]  regFileRzD,
  input  logic [1:0]  regSrcD,
  input  logic [7:0]  cpsr8W,
  // From the hazard unit
  input  logic        stallE,
  input  logic        flushE,
  input  logic        stallM,
  input  logic        flushM,
  input  logic        stallW,
  input  logic        flushW,
  // To the register file
  output regOneHotT   ra1D,
  output regOneHotT   ra2D,
  output regOneHotT   wa3W,
  // To the hazard unit
  output logic        match1DE,
  output logic        match2DE,
  output logic        match1EM,
  output logic        match2EM,
  output logic        match1EW,
  output logic        match2EW
);

  decodeAddrIf decBus ();
  pipeAddrIf   pipeBus ();

  // Read selects go straight out in Decode
  assign ra1D = decBus.ra1;
  assign ra2D = decBus.ra2;

  regAddrSelect u_select (
    .instrD      (instrD),
    .multSelectD (multSelectD),
    .aluSrcD     (aluSrcD),
    .regFileRzD  (regFileRzD),
    .regSrcD     (regSrcD),
    .cpsr8W      (cpsr8W),
    .dec         (decBus.producer)
  );

  addrPipeline u_pipeline (
    .clk    (clk),
    .rstN   (rstN),
    .stallE (stallE),
    .flushE (flushE),
    .stallM (stallM),
    .flushM (flushM),
    .stallW (stallW),
    .flushW (flushW),
    .dec    (decBus.consumer),
    .pipe   (pipeBus.producer),
    .wa3W   (wa3W)
  );

  hazardMatch u_match (
    .clk      (clk),
    .rstN     (rstN),
    .stallM   (stallM),
    .flushM   (flushM),
    .dec      (decBus.consumer),
    .pipe     (pipeBus.consumer),
    .match1DE (match1DE),
    .match2DE (match2DE),
    .match1EM (match1EM),
    .match2EM (match2EM),
    .match1EW (match1EW),
    .match2EW (match2EW)
  );

endmodule

`default_nettype wire

// ==== src/hazardMatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardMatch (
  input  logic          clk,
  input  logic          rstN,
  input  logic          stallM,
  input  logic          flushM,
  decodeAddrIf.consumer dec,
  pipeAddrIf.consumer   pipe,
  output logic          match1DE,
  output logic          match2DE,
  output logic          match1EM,
  output logic          match2EM,
  output logic          match1EW,
  output logic          match2EW
);

  logic wa3EValid;
  logic wa3WValid;

  // Zero destination means nothing is written
  assign wa3EValid = |pipe.wa3E;
  assign wa3WValid = |pipe.wa3W;

  // ==============================
  // Decode against Execute
  // ==============================
  assign match1DE = wa3EValid && (dec.ra1 == pipe.wa3E);
  // Immediate operand never matches
  assign match2DE = wa3EValid && dec.op2Reg && (dec.ra2 == pipe.wa3E);

  // Same pair seen from Memory one edge later
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      match1EM <= 1'b0;
      match2EM <= 1'b0;
    end else if (flushM) begin
      match1EM <= 1'b0;
      match2EM <= 1'b0;
    end else if (!stallM) begin
      match1EM <= match1DE;
      match2EM <= match2DE;
    end
  end

  // Execute reads against Writeback
  assign match1EW = wa3WValid && (pipe.ra1E == pipe.wa3W);
  assign match2EW = wa3WValid && pipe.op2RegE && (pipe.ra2E == pipe.wa3W);

  // A Decode hazard must name exactly one Execute destination
  assert property (@(posedge clk) disable iff (!rstN)
                   (match1DE || match2DE) |-> $onehot(pipe.wa3E))
    else $error("hazardMatch hit on a malformed Execute address");

endmodule

`default_nettype wire

// ==== src/addrPipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module addrPipeline
  import regBankPkg::*, pipeCtrlPkg::*;
(
  input  logic          clk,
  input  logic          rstN,
  input  logic          stallE,
  input  logic          flushE,
  input  logic          stallM,
  input  logic          flushM,
  input  logic          stallW,
  input  logic          flushW,
  decodeAddrIf.consumer dec,
  pipeAddrIf.producer   pipe,
  output regOneHotT     wa3W
);

  execAddrT execD;
  execAddrT execQ;
  memAddrT  memQ;
  wbAddrT   wbQ;

  assign execD = '{wa3: dec.wa3, ra1: dec.ra1, ra2: dec.ra2, op2Reg: dec.op2Reg};

  // ==============================
  // Stage registers
  // ==============================
  // Flush beats stall in every stage
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) execQ <= '0;
    else if (flushE) execQ <= '0;
    else if (!stallE) execQ <= execD;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) memQ <= '0;
    else if (flushM) memQ <= '0;
    else if (!stallM) memQ.wa3 <= execQ.wa3;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) wbQ <= '0;
    else if (flushW) wbQ <= '0;
    else if (!stallW) wbQ.wa3 <= memQ.wa3;
  end

  // Outputs for the match unit
  assign pipe.wa3E    = execQ.wa3;
  assign pipe.ra1E    = execQ.ra1;
  assign pipe.ra2E    = execQ.ra2;
  assign pipe.op2RegE = execQ.op2Reg;
  assign pipe.wa3W    = wbQ.wa3;
  assign wa3W         = wbQ.wa3;

  // Register file sees at most one write line
  assert property (@(posedge clk) disable iff (!rstN) $onehot0(wbQ.wa3))
    else $error("addrPipeline writeback address not one-hot");

endmodule

`default_nettype wire

// ==== src/regAddrSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module regAddrSelect
  import regBankPkg::*;
(
  input  logic [31:0]   instrD,
  input  logic          multSelectD,
  input  logic          aluSrcD,
  input  logic [3:0]    regFileRzD,
  input  logic [1:0]    regSrcD,
  input  logic [7:0]    cpsr8W,
  decodeAddrIf.producer dec
);

  regNumT  ra1RnNum;
  regNumT  ra1Num;
  regNumT  ra2Num;
  regNumT  wa3Num;
  cpuModeT mode;
  logic    regShiftOp;

  // Mode from the writeback copy of the status byte
  assign mode = cpuModeT'(cpsr8W[4:0]);

  // Register-shifted operand, Rs sits in bits 11:8
  assign regShiftOp = regFileRzD[2] & regFileRzD[3];

  // ==============================
  // Field selection
  // ==============================
  // First read, Rn or PC, Rm for multiply
  always_comb begin
    if (multSelectD) ra1RnNum = instrD[3:0];
    else if (regSrcD[0]) ra1RnNum = 4'hf;
    else ra1RnNum = instrD[19:16];
  end

  assign ra1Num = (regShiftOp && !multSelectD) ? instrD[11:8] : ra1RnNum;

  // Second read, Rm, Rd for stores, Rs for multiply
  always_comb begin
    if (multSelectD) ra2Num = instrD[11:8];
    else if (regSrcD[1]) ra2Num = instrD[15:12];
    else ra2Num = instrD[3:0];
  end

  // Multiply keeps Rd up in 19:16
  assign wa3Num = multSelectD ? instrD[19:16] : instrD[15:12];

  // Bits 3:0 hold an immediate unless all three hold low
  assign dec.op2Reg = ~multSelectD & ~regSrcD[1] & ~aluSrcD;

  // ==============================
  // Banked decode
  // ==============================
  bankAddrDecode u_ra1Dec (
    .regNum   (ra1Num),
    .userBank (regFileRzD[0]),
    .mode     (mode),
    .sel      (dec.ra1)
  );

  bankAddrDecode u_ra2Dec (
    .regNum   (ra2Num),
    .userBank (regFileRzD[1]),
    .mode     (mode),
    .sel      (dec.ra2)
  );

  bankAddrDecode u_wa3Dec (
    .regNum   (wa3Num),
    .userBank (regFileRzD[2]),
    .mode     (mode),
    .sel      (dec.wa3)
  );

endmodule

`default_nettype wire

// ==== src/bankAddrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module bankAddrDecode
  import regBankPkg::*;
(
  input  regNumT    regNum,
  input  logic      userBank,
  input  cpuModeT   mode,
  output regOneHotT sel
);

  logic [4:0] pairBase;
  logic       pairBanked;
  logic [4:0] physIdx;

  // SP/LR pair base for the exception modes
  always_comb begin
    pairBase   = userBase;
    pairBanked = 1'b1;
    case (mode)
      modeIrq:   pairBase = irqBase;
      modeSvc:   pairBase = svcBase;
      modeAbort: pairBase = abortBase;
      modeUndef: pairBase = undefBase;
      // User, system, fiq and unknown modes
      default:   pairBanked = 1'b0;
    endcase
  end

  // ==============================
  // Physical slot
  // ==============================
  always_comb begin
    // Shared bank unless a rule below applies
    physIdx = userBase + 5'(regNum);
    if (!userBank) begin
      // fiq banks R8 up to LR
      if (mode == modeFiq && regNum >= fiqFirstReg && regNum <= lrReg) begin
        physIdx = fiqBase + 5'(regNum - fiqFirstReg);
      end else if (pairBanked && (regNum == spReg || regNum == lrReg)) begin
        physIdx = pairBase + 5'(regNum - spReg);
      end
    end
  end

  always_comb begin
    sel          = '0;
    sel[physIdx] = 1'b1;
    // Bank arithmetic must never reach the spare slot
    assert (!sel[unusedPhys])
      else $error("bankAddrDecode bad select %h", sel);
  end

endmodule

`default_nettype wire

// ==== src/pipeAddrIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// Later-stage addresses from the pipeline buffer
interface pipeAddrIf
  import regBankPkg::*;
();

  regOneHotT wa3E;
  regOneHotT ra1E;
  regOneHotT ra2E;
  logic      op2RegE;
  regOneHotT wa3W;

  modport producer (
    output wa3E,
    output ra1E,
    output ra2E,
    output op2RegE,
    output wa3W
  );

  modport consumer (
    input wa3E,
    input ra1E,
    input ra2E,
    input op2RegE,
    input wa3W
  );

endinterface

`default_nettype wire

// ==== src/decodeAddrIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// Decode-stage register selects
interface decodeAddrIf
  import regBankPkg::*;
();

  regOneHotT ra1;
  regOneHotT ra2;
  regOneHotT wa3;
  // Operand 2 really is a register
  logic      op2Reg;

  modport producer (
    output ra1,
    output ra2,
    output wa3,
    output op2Reg
  );

  // Pipeline buffer and match unit both read
  modport consumer (
    input ra1,
    input ra2,
    input wa3,
    input op2Reg
  );

endinterface

`default_nettype wire

// ==== src/pipeCtrlPkg.sv ====
`default_nettype none

package pipeCtrlPkg;

  import regBankPkg::*;

  // Execute stage, all decoded addresses plus operand-2 source
  typedef struct packed {
    regOneHotT wa3;
    regOneHotT ra1;
    regOneHotT ra2;
    logic      op2Reg;
  } execAddrT;

  // Memory stage keeps only the destination
  typedef struct packed {
    regOneHotT wa3;
  } memAddrT;

  // Writeback destination, drives the register file write port
  typedef struct packed {
    regOneHotT wa3;
  } wbAddrT;

endpackage

`default_nettype wire

// ==== src/regBankPkg.sv ====
`default_nettype none

package regBankPkg;

  // Architectural register number from the instruction
  typedef logic [3:0] regNumT;

  // One select line per physical register, all zero for no register
  typedef logic [31:0] regOneHotT;

  // Low five bits of the status byte
  typedef enum logic [4:0] {
    modeUser   = 5'b10000,
    modeFiq    = 5'b10001,
    modeIrq    = 5'b10010,
    modeSvc    = 5'b10011,
    modeAbort  = 5'b10111,
    modeUndef  = 5'b11011,
    modeSystem = 5'b11111
  } cpuModeT;

  // ==============================
  // Banking map
  // ==============================
  // First physical slot of each bank
  localparam logic [4:0] userBase   = 5'd0;
  localparam logic [4:0] fiqBase    = 5'd16;
  localparam logic [4:0] irqBase    = 5'd23;
  localparam logic [4:0] svcBase    = 5'd25;
  localparam logic [4:0] abortBase  = 5'd27;
  localparam logic [4:0] undefBase  = 5'd29;
  // Spare slot, never selected
  localparam logic [4:0] unusedPhys = 5'd31;

  // Architectural registers that bank
  localparam regNumT fiqFirstReg = 4'd8;
  localparam regNumT spReg       = 4'd13;
  localparam regNumT lrReg       = 4'd14;

endpackage

`default_nettype wire
